/* source/gfx_settings.svh */
// Memory size, register offsets, display size and scan timing of the graphics subsystem.
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// Shared memory size in bytes. The register block starts right above it.
`define GFX_MEM_BYTES 4096

// Register offsets relative to GFX_MEM_BYTES.
`define GFX_REG_IMG_ADDR     32'h0000_0000
`define GFX_REG_SRC_X        32'h0000_0004
`define GFX_REG_SRC_Y        32'h0000_0008
`define GFX_REG_IMG_WIDTH    32'h0000_000C
`define GFX_REG_WIDTH        32'h0000_0010
`define GFX_REG_HEIGHT       32'h0000_0014
`define GFX_REG_DEST_X       32'h0000_0018
`define GFX_REG_DEST_Y       32'h0000_001C
`define GFX_REG_DRAW         32'h0000_0020
`define GFX_REG_CLEAR_COLOR  32'h0000_0024
`define GFX_REG_CLEAR        32'h0000_0028
`define GFX_REG_BUSY         32'h0000_002C
`define GFX_REG_SWAP         32'h0000_0100
`define GFX_REG_VSYNC        32'h0000_0108
`define GFX_REG_VSYNC_SYNCED 32'h0000_010C

// Display area and scan totals.
`define GFX_FB_WIDTH    32
`define GFX_FB_HEIGHT   24
`define GFX_H_TOTAL     40
`define GFX_V_TOTAL     28
`define GFX_VSYNC_LINES 2

`endif

/* source/gfx_pkg.sv */
// Pixel, coordinate, size and draw-command types of the graphics subsystem.
`include "gfx_settings.svh"

package gfx_pkg;

	// RGB565 pixel.
	typedef logic [15:0] pixel_t;

	typedef logic [$clog2(`GFX_FB_WIDTH)-1:0] fb_x_t;
	typedef logic [$clog2(`GFX_FB_HEIGHT)-1:0] fb_y_t;

	// A size must reach the full display width, so it is one bit wider than a coordinate.
	typedef logic [$clog2(`GFX_FB_WIDTH):0] fb_size_t;

	typedef struct packed {
		logic [31:0] img_addr;
		logic [15:0] src_x;
		logic [15:0] src_y;
		logic [15:0] img_width;
		fb_size_t    width;
		fb_size_t    height;
		fb_x_t       dest_x;
		fb_y_t       dest_y;
		pixel_t      clear_color;
	} draw_cmd_t;

endpackage

/* source/gfx_interfaces.sv */
// Interfaces gpu_mem_if, ram_port_if and fb_write_if with their modports.

// GPU halfword read port. Data comes back exactly one cycle after read.
interface gpu_mem_if;
	import gfx_pkg::*;
	logic        read;
	logic [31:0] addr;
	logic        valid;
	pixel_t      data;

	modport initiator (output read, output addr, input valid, input data);
	modport target (input read, input addr, output valid, output data);
endinterface

// CPU side memory port. A zero strobe is a read.
interface ram_port_if;
	logic        req;
	logic [3:0]  strb;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        ack;
	logic [31:0] rdata;

	modport initiator (output req, output strb, output addr, output wdata,
		input ack, input rdata);
	modport target (input req, input strb, input addr, input wdata,
		output ack, output rdata);
endinterface

// Single cycle pixel write into the back buffer.
interface fb_write_if;
	import gfx_pkg::*;
	logic   write;
	fb_x_t  x;
	fb_y_t  y;
	pixel_t color;

	modport initiator (output write, output x, output y, output color);
	modport target (input write, input x, input y, input color);
endinterface

/* source/sys_memory.sv */
// Shared word memory with a strobed CPU port and a prioritized GPU halfword read port.
`include "gfx_settings.svh"

module sys_memory (
	input logic hdmi_pixClk,
	input logic reset,
	gpu_mem_if.target gpu,
	ram_port_if.target cpu
);

	localparam int WORDS = `GFX_MEM_BYTES / 4;
	localparam int AW = $clog2(WORDS);

	logic [31:0]   mem [0:WORDS-1];
	logic [31:0]   gpu_word;
	logic          gpu_upper;
	logic [AW-1:0] gpu_index;
	logic [AW-1:0] cpu_index;
	logic          cpu_take;

	assign gpu_index = gpu.addr[AW+1:2];
	assign cpu_index = cpu.addr[AW+1:2];

	// The CPU only gets the array in a cycle without a GPU read.
	assign cpu_take = cpu.req && !cpu.ack && !gpu.read;

	assign gpu.data = gpu_upper ? gpu_word[31:16] : gpu_word[15:0];

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			gpu.valid <= 1'b0;
			cpu.ack <= 1'b0;
		end else begin
			gpu.valid <= gpu.read;
			cpu.ack <= cpu_take;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (gpu.read) begin
			gpu_word <= mem[gpu_index];
			gpu_upper <= gpu.addr[1];
		end else if (cpu_take) begin
			for (int b = 0; b < 4; b++) begin
				if (cpu.strb[b])
					mem[cpu_index][8*b +: 8] <= cpu.wdata[8*b +: 8];
			end
			if (cpu.strb == 4'b0000)
				cpu.rdata <= mem[cpu_index];
		end
	end

	// The initiator holds req through the ack and drops it in the cycle after.
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		cpu.ack |=> $past(cpu.req) && !cpu.req);

endmodule

/* source/mmio_regs.sv */
// CPU bus front end with address decode, ready generation and the GPU control registers.
`include "gfx_settings.svh"

module mmio_regs (
	input  logic              hdmi_pixClk,
	input  logic              reset,
	input  logic              mem_valid,
	input  logic [31:0]       mem_addr,
	input  logic [31:0]       mem_wdata,
	input  logic [3:0]        mem_wstrb,
	output logic              mem_ready,
	output logic [31:0]       mem_rdata,
	ram_port_if.initiator     ram,
	output gfx_pkg::draw_cmd_t draw_cmd,
	output logic              draw_start,
	output logic              clear_start,
	output logic              swap_req,
	output logic              vsync_synced,
	input  logic              busy,
	input  logic              vsync
);

	import gfx_pkg::*;

	localparam logic [31:0] REG_BASE = `GFX_MEM_BYTES;
	localparam pixel_t CLEAR_COLOR_INIT = 16'hD8B7;

	logic        in_mem;
	logic [31:0] reg_off;
	logic        reg_access;
	logic        full_write;
	logic        read_access;

	assign in_mem = mem_addr < REG_BASE;
	assign reg_off = mem_addr - REG_BASE;
	assign full_write = &mem_wstrb;
	assign read_access = mem_wstrb == 4'b0000;

	// Ready is a single pulse, so a request still held in the ready cycle is not taken twice.
	assign reg_access = mem_valid && !in_mem && !mem_ready;

	assign ram.req = mem_valid && in_mem && !mem_ready;
	assign ram.strb = mem_wstrb;
	assign ram.addr = mem_addr;
	assign ram.wdata = mem_wdata;

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			mem_ready <= 1'b0;
			draw_start <= 1'b0;
			clear_start <= 1'b0;
			swap_req <= 1'b0;
			vsync_synced <= 1'b1;
			draw_cmd.clear_color <= CLEAR_COLOR_INIT;
		end else begin
			mem_ready <= 1'b0;
			draw_start <= 1'b0;
			clear_start <= 1'b0;
			swap_req <= 1'b0;
			if (ram.ack) begin
				mem_ready <= 1'b1;
				mem_rdata <= ram.rdata;
			end else if (reg_access) begin
				mem_ready <= 1'b1;
				if (read_access) begin
					case (reg_off)
						`GFX_REG_BUSY:  mem_rdata <= {31'b0, busy};
						`GFX_REG_VSYNC: mem_rdata <= {31'b0, vsync};
						default:        mem_rdata <= 32'b0;
					endcase
				end else if (full_write) begin
					case (reg_off)
						`GFX_REG_IMG_ADDR:     draw_cmd.img_addr <= mem_wdata;
						`GFX_REG_SRC_X:        draw_cmd.src_x <= mem_wdata[15:0];
						`GFX_REG_SRC_Y:        draw_cmd.src_y <= mem_wdata[15:0];
						`GFX_REG_IMG_WIDTH:    draw_cmd.img_width <= mem_wdata[15:0];
						`GFX_REG_WIDTH:        draw_cmd.width <= fb_size_t'(mem_wdata);
						`GFX_REG_HEIGHT:       draw_cmd.height <= fb_size_t'(mem_wdata);
						`GFX_REG_DEST_X:       draw_cmd.dest_x <= fb_x_t'(mem_wdata);
						`GFX_REG_DEST_Y:       draw_cmd.dest_y <= fb_y_t'(mem_wdata);
						`GFX_REG_CLEAR_COLOR:  draw_cmd.clear_color <= mem_wdata[15:0];
						`GFX_REG_DRAW:         draw_start <= !busy;
						`GFX_REG_CLEAR:        clear_start <= !busy;
						`GFX_REG_SWAP:         swap_req <= 1'b1;
						`GFX_REG_VSYNC_SYNCED: vsync_synced <= mem_wdata[0];
						default: ;
					endcase
				end
			end
		end
	end

	// The core holds valid until it sees ready, so ready must never appear on its own.
	assert property (@(posedge hdmi_pixClk) disable iff (reset) mem_ready |-> mem_valid);

endmodule

/* source/gpu_blitter.sv */
// Rectangle copy and clear engine that writes pixels into the back buffer.
`include "gfx_settings.svh"

module gpu_blitter (
	input  logic               hdmi_pixClk,
	input  logic               reset,
	input  gfx_pkg::draw_cmd_t draw_cmd,
	input  logic               draw_start,
	input  logic               clear_start,
	output logic               busy,
	gpu_mem_if.initiator       mem,
	fb_write_if.initiator      fb
);

	import gfx_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_CLEAR} state_t;

	localparam logic [7:0] FB_W = 8'(`GFX_FB_WIDTH);
	localparam logic [7:0] FB_H = 8'(`GFX_FB_HEIGHT);

	state_t      state;
	draw_cmd_t   cmd;
	fb_size_t    col;
	fb_size_t    row;
	logic        last_col;
	logic        last_row;
	logic        step;
	logic [7:0]  pix_x;
	logic [7:0]  pix_y;
	logic        on_screen;
	logic [31:0] src_row;
	logic [31:0] src_col;

	assign busy = state != S_IDLE;
	assign last_col = col == cmd.width - 1'b1;
	assign last_row = row == cmd.height - 1'b1;

	// One pixel is done per write cycle of a draw, or per cycle of a clear.
	assign step = (state == S_WRITE && mem.valid) || state == S_CLEAR;

	assign src_row = 32'(cmd.src_y) + 32'(row);
	assign src_col = 32'(cmd.src_x) + 32'(col);
	assign mem.read = state == S_READ;
	assign mem.addr = cmd.img_addr + ((src_row * 32'(cmd.img_width) + src_col) << 1);

	assign pix_x = 8'(cmd.dest_x) + 8'(col);
	assign pix_y = 8'(cmd.dest_y) + 8'(row);
	assign on_screen = pix_x < FB_W && pix_y < FB_H;

	assign fb.write = step && on_screen;
	assign fb.x = fb_x_t'(pix_x);
	assign fb.y = fb_y_t'(pix_y);
	assign fb.color = (state == S_CLEAR) ? cmd.clear_color : mem.data;

	// ********************
	// Sequencing

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			state <= S_IDLE;
			col <= '0;
			row <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					col <= '0;
					row <= '0;
					if (draw_start && draw_cmd.width != '0 && draw_cmd.height != '0)
						state <= S_READ;
					else if (clear_start)
						state <= S_CLEAR;
				end
				S_READ: state <= S_WRITE;
				S_WRITE: if (mem.valid) state <= (last_col && last_row) ? S_IDLE : S_READ;
				S_CLEAR: if (last_col && last_row) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
			if (step) begin
				if (last_col) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// The command is captured at the start so the CPU may set up the next one meanwhile.
	always_ff @(posedge hdmi_pixClk) begin
		if (state == S_IDLE) begin
			cmd <= draw_cmd;
			if (clear_start) begin
				cmd.dest_x <= '0;
				cmd.dest_y <= '0;
				cmd.width <= fb_size_t'(`GFX_FB_WIDTH);
				cmd.height <= fb_size_t'(`GFX_FB_HEIGHT);
			end
		end
	end

	// While running, the walk never leaves the rectangle of the captured command.
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		busy |-> col < cmd.width && row < cmd.height);

endmodule

/* source/framebuffer.sv */
// Double pixel buffer with back buffer writes, registered front buffer reads and a swap.
`include "gfx_settings.svh"

module framebuffer (
	input  logic            hdmi_pixClk,
	input  logic            reset,
	fb_write_if.target      wr,
	input  logic            swap_req,
	input  logic            vsync_synced,
	input  logic            frame_start,
	input  gfx_pkg::fb_x_t  x,
	input  gfx_pkg::fb_y_t  y,
	input  logic            de,
	output gfx_pkg::pixel_t pixel
);

	import gfx_pkg::*;

	localparam int DEPTH = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;
	localparam int AW = $clog2(DEPTH);

	pixel_t buf0 [0:DEPTH-1];
	pixel_t buf1 [0:DEPTH-1];
	logic   front;
	logic   swap_pending;
	logic   show;

	function automatic logic [AW-1:0] pixel_index(fb_x_t px, fb_y_t py);
		return AW'(int'(py) * `GFX_FB_WIDTH + int'(px));
	endfunction

	// A pending swap already shows in the first pixel of the new frame.
	assign show = front ^ (swap_pending && frame_start);

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			front <= 1'b0;
			swap_pending <= 1'b0;
		end else if (swap_pending && frame_start) begin
			front <= ~front;
			swap_pending <= 1'b0;
		end else if (swap_req) begin
			if (vsync_synced)
				swap_pending <= 1'b1;
			else
				front <= ~front;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr.write) begin
			if (front)
				buf0[pixel_index(wr.x, wr.y)] <= wr.color;
			else
				buf1[pixel_index(wr.x, wr.y)] <= wr.color;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!de)
			pixel <= '0;
		else if (show)
			pixel <= buf1[pixel_index(x, y)];
		else
			pixel <= buf0[pixel_index(x, y)];
	end

endmodule

/* source/video_timing.sv */
// Scan counters producing coordinates, sync signals, data-enable and the frame-start strobe.
`include "gfx_settings.svh"

module video_timing (
	input  logic           hdmi_pixClk,
	input  logic           reset,
	output gfx_pkg::fb_x_t x,
	output gfx_pkg::fb_y_t y,
	output logic           de,
	output logic           hsync,
	output logic           vsync,
	output logic           frame_start
);

	import gfx_pkg::*;

	localparam int HW = $clog2(`GFX_H_TOTAL);
	localparam int VW = $clog2(`GFX_V_TOTAL);
	localparam logic [HW-1:0] H_LAST = HW'(`GFX_H_TOTAL - 1);
	localparam logic [VW-1:0] V_LAST = VW'(`GFX_V_TOTAL - 1);
	localparam logic [HW-1:0] H_ACTIVE = HW'(`GFX_FB_WIDTH);
	localparam logic [VW-1:0] V_ACTIVE = VW'(`GFX_FB_HEIGHT);
	localparam logic [HW-1:0] H_SYNC = HW'(`GFX_H_TOTAL - 4);
	localparam logic [VW-1:0] V_SYNC = VW'(`GFX_V_TOTAL - `GFX_VSYNC_LINES);

	logic [HW-1:0] h_count;
	logic [VW-1:0] v_count;

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == H_LAST) begin
			h_count <= '0;
			v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign x = fb_x_t'(h_count);
	assign y = fb_y_t'(v_count);
	assign de = h_count < H_ACTIVE && v_count < V_ACTIVE;
	assign hsync = h_count >= H_SYNC;
	assign vsync = v_count >= V_SYNC;
	assign frame_start = h_count == '0 && v_count == '0;

endmodule

/* source/gfx_subsystem.sv */
// Graphics subsystem top level joining memory, registers, blitter, framebuffer and scan.
module gfx_subsystem (
	input  logic        hdmi_pixClk,
	input  logic        reset,
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_wstrb,
	output logic        mem_ready,
	output logic [31:0] mem_rdata,
	output logic [15:0] pix_data,
	output logic        pix_de,
	output logic        hsync,
	output logic        vsync
);

	import gfx_pkg::*;

	gpu_mem_if  gpu_mem ();
	ram_port_if ram_port ();
	fb_write_if fb_wr ();

	draw_cmd_t draw_cmd;
	logic      draw_start;
	logic      clear_start;
	logic      busy;
	logic      swap_req;
	logic      vsync_synced;
	logic      frame_start;
	fb_x_t     scan_x;
	fb_y_t     scan_y;
	logic      scan_de;
	logic      scan_hsync;
	logic      scan_vsync;

	sys_memory sys_memory_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset), .gpu(gpu_mem), .cpu(ram_port)
	);

	mmio_regs mmio_regs_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.ram(ram_port), .draw_cmd(draw_cmd), .draw_start(draw_start),
		.clear_start(clear_start), .swap_req(swap_req), .vsync_synced(vsync_synced),
		.busy(busy), .vsync(scan_vsync)
	);

	gpu_blitter gpu_blitter_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset), .draw_cmd(draw_cmd),
		.draw_start(draw_start), .clear_start(clear_start), .busy(busy),
		.mem(gpu_mem), .fb(fb_wr)
	);

	framebuffer framebuffer_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset), .wr(fb_wr), .swap_req(swap_req),
		.vsync_synced(vsync_synced), .frame_start(frame_start),
		.x(scan_x), .y(scan_y), .de(scan_de), .pixel(pix_data)
	);

	video_timing video_timing_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset), .x(scan_x), .y(scan_y),
		.de(scan_de), .hsync(scan_hsync), .vsync(scan_vsync), .frame_start(frame_start)
	);

	// Pixel data leaves the framebuffer one cycle late, so the controls follow it.
	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			pix_de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			pix_de <= scan_de;
			hsync <= scan_hsync;
			vsync <= scan_vsync;
		end
	end

endmodule

/* sim/tb_gfx_subsystem.sv */
// Directed testbench of the graphics subsystem with bus tasks, frame capture, checks and a timeout.
`include "gfx_settings.svh"

module tb_gfx_subsystem;

	timeunit 1ns;
	timeprecision 100ps;

	import gfx_pkg::*;

	localparam logic [31:0] REGS = `GFX_MEM_BYTES;
	localparam int FB_W = `GFX_FB_WIDTH;
	localparam int PIXELS = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;
	localparam int FRAME_CYCLES = `GFX_H_TOTAL * `GFX_V_TOTAL;
	localparam int NUM_TESTS = 5;
	localparam int CYCLE_LIMIT = NUM_TESTS * 4 * FRAME_CYCLES + 2000;
	localparam logic [31:0] IMG_ADDR = 32'h0000_0400;
	localparam int IMG_SIZE = 8;

	logic        hdmi_pixClk;
	logic        reset;
	logic        mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        mem_ready;
	logic [31:0] mem_rdata;
	logic [15:0] pix_data;
	logic        pix_de;
	logic        hsync;
	logic        vsync;

	int          errors = 0;
	int          cycles = 0;
	int          seed = 60789;
	int          shown = 0;
	pixel_t      frame [PIXELS];
	pixel_t      fb_model [2][PIXELS];
	logic [31:0] mem_model [`GFX_MEM_BYTES/4];

	gfx_subsystem gfx_subsystem_inst (
		.hdmi_pixClk(hdmi_pixClk), .reset(reset),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.pix_data(pix_data), .pix_de(pix_de), .hsync(hsync), .vsync(vsync)
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #4 hdmi_pixClk = ~hdmi_pixClk;
	end

	always @(posedge hdmi_pixClk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ********************
	// Bus and check helpers

	// Inputs change and outputs are sampled 1 ns after the rising edge.
	task automatic next_cycle();
		@(posedge hdmi_pixClk);
		#1;
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	// Valid stays up through the ready cycle, as the core only sees ready at the next edge.
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, output logic [31:0] rdata);
		next_cycle();
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = strb;
		do next_cycle(); while (!mem_ready);
		rdata = mem_rdata;
		next_cycle();
		mem_valid = 1'b0;
		mem_wstrb = 4'b0000;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] unused_data;
		int index;
		bus_access(addr, data, strb, unused_data);
		index = int'(addr >> 2);
		if (addr < REGS) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b])
					mem_model[index][8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		bus_access(addr, 32'd0, 4'b0000, data);
	endtask

	task automatic reg_write(input logic [31:0] offset, input logic [31:0] data);
		bus_write(REGS + offset, data, 4'b1111);
	endtask

	task automatic wait_idle();
		logic [31:0] value;
		bus_read(REGS + `GFX_REG_BUSY, value);
		while (value[0])
			bus_read(REGS + `GFX_REG_BUSY, value);
	endtask

	// ********************
	// Framebuffer model and capture

	task automatic run_clear(input pixel_t color);
		reg_write(`GFX_REG_CLEAR_COLOR, 32'(color));
		reg_write(`GFX_REG_CLEAR, 32'd1);
		wait_idle();
		for (int i = 0; i < PIXELS; i++)
			fb_model[1 - shown][i] = color;
	endtask

	// Source pixel address is image address plus twice the linear halfword index.
	task automatic model_draw(input int sx, input int sy, input int w, input int h,
			input int dx, input int dy);
		int byte_addr;
		logic [31:0] word;
		for (int row = 0; row < h; row++) begin
			for (int col = 0; col < w; col++) begin
				byte_addr = int'(IMG_ADDR) + 2 * ((sy + row) * IMG_SIZE + sx + col);
				word = mem_model[byte_addr / 4];
				if (dx + col < `GFX_FB_WIDTH && dy + row < `GFX_FB_HEIGHT)
					fb_model[1 - shown][(dy + row) * FB_W + dx + col] =
						(byte_addr % 4 != 0) ? word[31:16] : word[15:0];
			end
		end
	endtask

	task automatic run_draw(input int sx, input int sy, input int w, input int h,
			input int dx, input int dy);
		reg_write(`GFX_REG_IMG_ADDR, IMG_ADDR);
		reg_write(`GFX_REG_SRC_X, sx);
		reg_write(`GFX_REG_SRC_Y, sy);
		reg_write(`GFX_REG_IMG_WIDTH, IMG_SIZE);
		reg_write(`GFX_REG_WIDTH, w);
		reg_write(`GFX_REG_HEIGHT, h);
		reg_write(`GFX_REG_DEST_X, dx);
		reg_write(`GFX_REG_DEST_Y, dy);
		reg_write(`GFX_REG_DRAW, 32'd1);
		wait_idle();
		model_draw(sx, sy, w, h, dx, dy);
	endtask

	task automatic swap_buffers(input logic synced);
		reg_write(`GFX_REG_VSYNC_SYNCED, {31'b0, synced});
		reg_write(`GFX_REG_SWAP, 32'd1);
		shown = 1 - shown;
	endtask

	// The first active pixel is already on the outputs in the cycle vsync falls.
	// From there hsync must be high in the last 4 columns of every line.
	task automatic capture_frame();
		int n;
		int col;
		next_cycle();
		while (!vsync)
			next_cycle();
		while (vsync)
			next_cycle();
		n = 0;
		col = 0;
		while (n < PIXELS) begin
			check_value(32'(hsync), 32'(col >= `GFX_H_TOTAL - 4),
				$sformatf("hsync at column %0d", col));
			if (pix_de) begin
				frame[n] = pix_data;
				n++;
			end
			if (n < PIXELS) begin
				next_cycle();
				col = (col + 1) % `GFX_H_TOTAL;
			end
		end
	endtask

	task automatic compare_frame(input string name);
		for (int i = 0; i < PIXELS; i++)
			check_value(32'(frame[i]), 32'(fb_model[shown][i]),
				$sformatf("%s pixel (%0d,%0d)", name, i % FB_W, i / FB_W));
	endtask

	// ********************
	// Tests

	task automatic memory_strobes();
		logic [31:0] value;
		bus_write(32'h0000_0100, 32'h1122_3344, 4'b1111);
		bus_write(32'h0000_0100, 32'hAABB_CCDD, 4'b0001);
		bus_write(32'h0000_0100, 32'h5566_7788, 4'b0100);
		bus_write(32'h0000_0104, 32'hCAFE_F00D, 4'b1111);
		bus_write(32'h0000_0104, 32'h0102_0304, 4'b1010);
		bus_read(32'h0000_0100, value);
		check_value(value, 32'h1166_33DD, "byte merge at 0x100");
		bus_read(32'h0000_0104, value);
		check_value(value, 32'h01FE_030D, "byte merge at 0x104");
	endtask

	// Vertical sync lasts two whole lines, so a read started at its edge lands inside it.
	task automatic register_reads();
		logic [31:0] value;
		bus_read(REGS + `GFX_REG_BUSY, value);
		check_value(value, 32'd0, "busy register when idle");
		while (!vsync)
			next_cycle();
		bus_read(REGS + `GFX_REG_VSYNC, value);
		check_value(value, 32'd1, "vsync register during sync");
		while (vsync)
			next_cycle();
		bus_read(REGS + `GFX_REG_VSYNC, value);
		check_value(value, 32'd0, "vsync register outside sync");
		bus_read(REGS + 32'h0000_0200, value);
		check_value(value, 32'd0, "unmapped register read");
	endtask

	task automatic clear_and_swap();
		run_clear(16'h5AA5);
		capture_frame();
		compare_frame("frame before swap");
		swap_buffers(1'b0);
		capture_frame();
		compare_frame("frame after immediate swap");
	endtask

	task automatic draw_image();
		for (int i = 0; i < IMG_SIZE * IMG_SIZE / 2; i++)
			bus_write(IMG_ADDR + 32'(4 * i), $random(seed), 4'b1111);
		run_clear(16'h0000);
		run_draw(2, 1, 5, 6, 10, 7);
		swap_buffers(1'b1);
		capture_frame();
		compare_frame("drawn frame");
	endtask

	task automatic draw_clipped();
		logic [31:0] value;
		logic [31:0] guard_addr;
		for (int i = 0; i < 4; i++)
			bus_write(IMG_ADDR + 32'(128 + 4 * i), 32'hC0DE_0000 | 32'(i), 4'b1111);
		run_draw(0, 0, 8, 8, 28, 20);
		swap_buffers(1'b1);
		capture_frame();
		compare_frame("clipped frame");
		for (int i = 0; i < 4; i++) begin
			guard_addr = IMG_ADDR + 32'(128 + 4 * i);
			bus_read(guard_addr, value);
			check_value(value, mem_model[int'(guard_addr >> 2)], "memory beyond image");
		end
	endtask

	initial begin
		mem_valid = 1'b0;
		mem_addr = 32'd0;
		mem_wdata = 32'd0;
		mem_wstrb = 4'b0000;
		reset = 1'b1;
		for (int i = 0; i < `GFX_MEM_BYTES / 4; i++)
			mem_model[i] = 32'd0;
		for (int i = 0; i < PIXELS; i++) begin
			fb_model[0][i] = 16'h0000;
			fb_model[1][i] = 16'h0000;
		end
		repeat (8) @(posedge hdmi_pixClk);
		#1;
		check_value(32'({mem_ready, pix_de, hsync, vsync}), 32'd0, "outputs during reset");
		reset = 1'b0;

		memory_strobes();
		register_reads();
		clear_and_swap();
		draw_image();
		draw_clipped();

		$display("Simulation finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* gfx_subsystem.f */
+incdir+source
source/gfx_pkg.sv
source/gfx_interfaces.sv
source/sys_memory.sv
source/mmio_regs.sv
source/gpu_blitter.sv
source/framebuffer.sv
source/video_timing.sv
source/gfx_subsystem.sv
sim/tb_gfx_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --x-initial 0 -j 0 \
	--top-module tb_gfx_subsystem -f gfx_subsystem.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_gfx_subsystem)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
